/* lmk_config.svh */
// build-time sizing for the LMK04806 configuration path, included by packages and RTL
`ifndef LMK_CONFIG_SVH
`define LMK_CONFIG_SVH

////////////////////////////////////////////////////////////
// link and frame sizing
////////////////////////////////////////////////////////////
`define LMK_NUM_CHIPS   2
`define LMK_CHIP_W      1
`define LMK_WORD_W      32
`define LMK_ADDR_W      5

////////////////////////////////////////////////////////////
// frames per operation
////////////////////////////////////////////////////////////
`define LMK_INIT_WORDS  14
`define LMK_WRITE_WORDS 3
`define LMK_READ_WORDS  2

`endif

/* lmk_pkg.sv */
// command and control types shared by the sequencer, the SPI channels and the readback merge
`include "lmk_config.svh"

package lmk_pkg;

  // one SPI frame, sent MSB first
  typedef logic [`LMK_WORD_W-1:0]    lmk_word_t;
  typedef logic [`LMK_ADDR_W-1:0]    lmk_addr_t;
  typedef logic [`LMK_NUM_CHIPS-1:0] lmk_chip_mask_t;

  // position of a frame inside one operation
  typedef logic [3:0] lmk_frame_idx_t;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_INIT,
    OP_WRITE,
    OP_READ
  } lmk_op_e;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_ISSUE,
    SEQ_WAIT
  } lmk_seq_state_e;

  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_SHIFT,
    SPI_GAP
  } lmk_spi_state_e;

endpackage

/* lmk_regmap_pkg.sv */
// LMK04806 register map constants and the per-chip power-up tables used by the SPI channels
`include "lmk_config.svh"

package lmk_regmap_pkg;

  typedef lmk_pkg::lmk_word_t lmk_init_row_t [`LMK_INIT_WORDS];
  typedef lmk_init_row_t lmk_init_table_t [`LMK_NUM_CHIPS];

  // low half of a readback-select word, register 31 with read bit
  typedef logic [15:0] lmk_rb_low_t;

  ////////////////////////////////////////////////////////////
  // fixed control words
  ////////////////////////////////////////////////////////////
  localparam lmk_pkg::lmk_word_t LMK_UNLOCK_WORD = 32'h0000_001F;
  localparam lmk_pkg::lmk_word_t LMK_LOCK_WORD   = 32'h0000_003F;

  localparam lmk_rb_low_t LMK_RB_LOW_BITS = 16'h001F;
  // readback address sits in bits 20:16
  localparam int          LMK_RB_ADDR_LSB = 16;

  ////////////////////////////////////////////////////////////
  // power-up tables, reset word then R0..R11 then R31
  ////////////////////////////////////////////////////////////
  localparam lmk_init_table_t LMK_INIT_TABLE = '{
    // chip 0, ADC board clock
    '{
      32'h8016_0180,
      32'h8014_0300,
      32'h0014_0181,
      32'h0014_0182,
      32'h0014_0063,
      32'h4014_0024,
      32'h8014_0605,
      32'h0100_0006,
      32'h0111_0007,
      32'h0001_0008,
      32'h5555_5549,
      32'h90C2_410A,
      32'h040C_300B,
      LMK_LOCK_WORD
    },
    // chip 1, different output dividers
    '{
      32'h8016_0180,
      32'h8014_0320,
      32'h8014_0321,
      32'h8014_0142,
      32'h4014_0023,
      32'h8014_0324,
      32'h8014_0325,
      32'h0000_0006,
      32'h0100_0007,
      32'h0000_0008,
      32'h5555_5549,
      32'h9002_410A,
      32'h340C_300B,
      LMK_LOCK_WORD
    }
  };

endpackage

/* lmk_frame_if.sv */
// per-chip frame request link from the command sequencer to one SPI channel
interface lmk_frame_if;
  import lmk_pkg::*;

  // one-cycle request, payload held until frame_done
  logic           frame_start;
  lmk_op_e        op;
  lmk_frame_idx_t frame_idx;
  lmk_word_t      wdata;
  lmk_addr_t      rd_addr;
  // one-cycle strobe after the inter-frame gap
  logic           frame_done;

  modport seq (
    output frame_start, op, frame_idx, wdata, rd_addr,
    input  frame_done
  );

  modport chan (
    input  frame_start, op, frame_idx, wdata, rd_addr,
    output frame_done
  );

endinterface

/* lmk_cmd_seq.sv */
// accepts init, write and read commands and steps each operation one frame at a time
`include "lmk_config.svh"

module lmk_cmd_seq (
  input  logic                    cfg_spi_clk,
  input  logic                    cfg_rst_in,
  input  logic                    cmd_valid,
  input  lmk_pkg::lmk_op_e        cmd_op,
  input  lmk_pkg::lmk_chip_mask_t cmd_mask,
  input  lmk_pkg::lmk_addr_t      cmd_addr,
  input  lmk_pkg::lmk_word_t      cmd_data,
  lmk_frame_if.seq                frame [`LMK_NUM_CHIPS],
  output logic                    busy,
  output logic                    done
);
  import lmk_pkg::*;

  lmk_seq_state_e state_q;
  lmk_op_e        op_q;
  lmk_chip_mask_t mask_q;
  lmk_chip_mask_t pend_q;
  lmk_chip_mask_t pend_left;
  lmk_chip_mask_t done_vec;
  lmk_addr_t      addr_q;
  lmk_word_t      data_q;
  lmk_frame_idx_t idx_q;
  lmk_frame_idx_t last_idx;
  logic           accept;

  function automatic lmk_frame_idx_t last_frame(lmk_op_e op);
    case (op)
      OP_INIT:  return lmk_frame_idx_t'(`LMK_INIT_WORDS - 1);
      OP_WRITE: return lmk_frame_idx_t'(`LMK_WRITE_WORDS - 1);
      OP_READ:  return lmk_frame_idx_t'(`LMK_READ_WORDS - 1);
      default:  return '0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // per-chip request fan-out
  ////////////////////////////////////////////////////////////
  for (genvar g = 0; g < `LMK_NUM_CHIPS; g++) begin : g_frame
    assign frame[g].frame_start = (state_q == SEQ_ISSUE) && mask_q[g];
    assign frame[g].op          = op_q;
    assign frame[g].frame_idx   = idx_q;
    assign frame[g].wdata       = data_q;
    assign frame[g].rd_addr     = addr_q;
    assign done_vec[g]          = frame[g].frame_done;
  end

  // empty mask or no opcode is dropped
  assign accept    = cmd_valid && (cmd_op != OP_NONE) && (|cmd_mask);
  assign last_idx  = last_frame(op_q);
  assign pend_left = pend_q & ~done_vec;
  assign busy      = (state_q != SEQ_IDLE);

  always_ff @(posedge cfg_spi_clk) begin
    if (cfg_rst_in) begin
      state_q <= SEQ_IDLE;
      op_q    <= OP_NONE;
      mask_q  <= '0;
      pend_q  <= '0;
      idx_q   <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state_q)
        SEQ_IDLE: begin
          if (accept) begin
            op_q    <= cmd_op;
            mask_q  <= cmd_mask;
            idx_q   <= '0;
            state_q <= SEQ_ISSUE;
          end
        end
        SEQ_ISSUE: begin
          pend_q  <= mask_q;
          state_q <= SEQ_WAIT;
        end
        SEQ_WAIT: begin
          pend_q <= pend_left;
          // all selected links finished this frame
          if (pend_left == '0) begin
            if (idx_q == last_idx) begin
              done    <= 1'b1;
              state_q <= SEQ_IDLE;
            end else begin
              idx_q   <= idx_q + 1'b1;
              state_q <= SEQ_ISSUE;
            end
          end
        end
        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

  // command payload
  always_ff @(posedge cfg_spi_clk) begin
    if (state_q == SEQ_IDLE && accept) begin
      addr_q <= cmd_addr;
      data_q <= cmd_data;
    end
  end

endmodule

/* lmk_spi_channel.sv */
// one LMK04806 SPI link: picks the frame word, shifts it out and captures the readback bits
`include "lmk_config.svh"

module lmk_spi_channel #(
  parameter int CHIP_ID = 0
) (
  input  logic               cfg_spi_clk,
  input  logic               cfg_rst_in,
  input  logic               spi_sdo,
  lmk_frame_if.chan          frame,
  output logic               spi_clk,
  output logic               spi_cs,
  output logic               spi_sdi,
  output logic               cap_valid,
  output lmk_pkg::lmk_word_t cap_data
);
  import lmk_pkg::*;
  import lmk_regmap_pkg::*;

  localparam int BIT_W = $clog2(`LMK_WORD_W);

  lmk_spi_state_e   state_q;
  logic             clk_q;
  logic             cs_q;
  logic             sdi_q;
  logic [BIT_W-1:0] bit_cnt_q;
  logic             done_q;
  logic             cap_valid_q;
  lmk_word_t        sh_q;
  lmk_word_t        cap_q;
  lmk_word_t        frame_word;
  logic             last_rd;

  ////////////////////////////////////////////////////////////
  // frame word select
  ////////////////////////////////////////////////////////////
  always_comb begin
    frame_word = '0;
    case (frame.op)
      OP_INIT: begin
        if (frame.frame_idx < `LMK_INIT_WORDS) begin
          frame_word = LMK_INIT_TABLE[CHIP_ID][frame.frame_idx];
        end
      end
      // unlock, user word, lock
      OP_WRITE: begin
        case (frame.frame_idx)
          4'd0:    frame_word = LMK_UNLOCK_WORD;
          4'd1:    frame_word = frame.wdata;
          default: frame_word = LMK_LOCK_WORD;
        endcase
      end
      // select word first, then a zero frame to clock data out
      OP_READ: begin
        if (frame.frame_idx == '0) begin
          frame_word[LMK_RB_ADDR_LSB +: `LMK_ADDR_W] = frame.rd_addr;
          frame_word[LMK_RB_ADDR_LSB-1:0]            = LMK_RB_LOW_BITS;
        end
      end
      default: ;
    endcase
  end

  assign last_rd = (frame.op == OP_READ) &&
                   (frame.frame_idx == lmk_frame_idx_t'(`LMK_READ_WORDS - 1));

  ////////////////////////////////////////////////////////////
  // link FSM, two cycles per bit
  ////////////////////////////////////////////////////////////
  always_ff @(posedge cfg_spi_clk) begin
    if (cfg_rst_in) begin
      state_q     <= SPI_IDLE;
      clk_q       <= 1'b0;
      cs_q        <= 1'b1;
      sdi_q       <= 1'b0;
      bit_cnt_q   <= '0;
      done_q      <= 1'b0;
      cap_valid_q <= 1'b0;
    end else begin
      done_q      <= 1'b0;
      cap_valid_q <= 1'b0;
      case (state_q)
        SPI_IDLE: begin
          if (frame.frame_start) begin
            cs_q      <= 1'b0;
            sdi_q     <= frame_word[`LMK_WORD_W-1];
            bit_cnt_q <= '0;
            state_q   <= SPI_SHIFT;
          end
        end
        SPI_SHIFT: begin
          clk_q <= ~clk_q;
          if (clk_q) begin
            if (bit_cnt_q == BIT_W'(`LMK_WORD_W - 1)) begin
              cs_q      <= 1'b1;
              sdi_q     <= 1'b0;
              bit_cnt_q <= '0;
              state_q   <= SPI_GAP;
            end else begin
              sdi_q     <= sh_q[`LMK_WORD_W-2];
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
          end
        end
        SPI_GAP: begin
          // bit counter doubles as the gap counter
          if (bit_cnt_q[0]) begin
            done_q      <= 1'b1;
            cap_valid_q <= last_rd;
            state_q     <= SPI_IDLE;
          end else begin
            bit_cnt_q <= 1'b1;
          end
        end
        default: state_q <= SPI_IDLE;
      endcase
    end
  end

  // shift and capture registers
  always_ff @(posedge cfg_spi_clk) begin
    if (state_q == SPI_IDLE && frame.frame_start) begin
      sh_q <= frame_word;
    end else if (state_q == SPI_SHIFT && clk_q) begin
      sh_q <= sh_q << 1;
    end
    // sdo sampled as clk rises
    if (state_q == SPI_SHIFT && !clk_q) begin
      cap_q <= {cap_q[`LMK_WORD_W-2:0], spi_sdo};
    end
  end

  assign spi_clk          = clk_q;
  assign spi_cs           = cs_q;
  assign spi_sdi          = sdi_q;
  assign frame.frame_done = done_q;
  assign cap_valid        = cap_valid_q;
  assign cap_data         = cap_q;

endmodule

/* lmk_rd_merge.sv */
// holds readback words from every link and drains them one per cycle, lowest chip first
`include "lmk_config.svh"

module lmk_rd_merge (
  input  logic                    cfg_spi_clk,
  input  logic                    cfg_rst_in,
  input  logic [`LMK_NUM_CHIPS-1:0] cap_valid,
  input  lmk_pkg::lmk_word_t      cap_data [`LMK_NUM_CHIPS],
  output logic                    rd_valid,
  output lmk_pkg::lmk_word_t      rd_data,
  output logic [`LMK_CHIP_W-1:0]  rd_chip
);
  import lmk_pkg::*;

  lmk_chip_mask_t         pend_q;
  lmk_chip_mask_t         sel_hot;
  logic [`LMK_CHIP_W-1:0] sel_chip;
  lmk_word_t              hold_q [`LMK_NUM_CHIPS];

  // lowest pending chip wins
  always_comb begin
    sel_chip = '0;
    sel_hot  = '0;
    for (int i = `LMK_NUM_CHIPS - 1; i >= 0; i--) begin
      if (pend_q[i]) begin
        sel_chip = `LMK_CHIP_W'(i);
        sel_hot  = lmk_chip_mask_t'(1) << i;
      end
    end
  end

  always_ff @(posedge cfg_spi_clk) begin
    if (cfg_rst_in) begin
      pend_q <= '0;
    end else begin
      pend_q <= (pend_q & ~sel_hot) | cap_valid;
    end
  end

  always_ff @(posedge cfg_spi_clk) begin
    for (int i = 0; i < `LMK_NUM_CHIPS; i++) begin
      if (cap_valid[i]) begin
        hold_q[i] <= cap_data[i];
      end
    end
  end

  assign rd_valid = |pend_q;
  assign rd_data  = hold_q[sel_chip];
  assign rd_chip  = sel_chip;

endmodule

/* lmk_cfg_top.sv */
// top level of the LMK04806 configuration block, one SPI link per chip
`include "lmk_config.svh"

module lmk_cfg_top (
  input  logic                      cfg_spi_clk,
  input  logic                      cfg_rst_in,
  input  logic                      lmk_cfg_valid,
  input  lmk_pkg::lmk_op_e          lmk_cfg_op,
  input  lmk_pkg::lmk_chip_mask_t   lmk_cfg_mask,
  input  lmk_pkg::lmk_addr_t        lmk_cfg_addr,
  input  lmk_pkg::lmk_word_t        lmk_cfg_data,
  input  logic [`LMK_NUM_CHIPS-1:0] lmk_spi_sdo,
  output logic [`LMK_NUM_CHIPS-1:0] lmk_spi_clk,
  output logic [`LMK_NUM_CHIPS-1:0] lmk_spi_cs,
  output logic [`LMK_NUM_CHIPS-1:0] lmk_spi_sdi,
  output logic                      lmk_busy,
  output logic                      lmk_done,
  output logic                      lmk_rd_valid,
  output lmk_pkg::lmk_word_t        lmk_rd_parameter,
  output logic [`LMK_CHIP_W-1:0]    lmk_rd_chip
);
  import lmk_pkg::*;

  lmk_frame_if frame_bus [`LMK_NUM_CHIPS] ();

  logic [`LMK_NUM_CHIPS-1:0] cap_valid;
  lmk_word_t                 cap_data [`LMK_NUM_CHIPS];

  lmk_cmd_seq u_cmd_seq (
    .cfg_spi_clk (cfg_spi_clk),
    .cfg_rst_in  (cfg_rst_in),
    .cmd_valid   (lmk_cfg_valid),
    .cmd_op      (lmk_cfg_op),
    .cmd_mask    (lmk_cfg_mask),
    .cmd_addr    (lmk_cfg_addr),
    .cmd_data    (lmk_cfg_data),
    .frame       (frame_bus),
    .busy        (lmk_busy),
    .done        (lmk_done)
  );

  ////////////////////////////////////////////////////////////
  // one channel per chip
  ////////////////////////////////////////////////////////////
  for (genvar g = 0; g < `LMK_NUM_CHIPS; g++) begin : g_chan
    lmk_spi_channel #(
      .CHIP_ID (g)
    ) u_spi_channel (
      .cfg_spi_clk (cfg_spi_clk),
      .cfg_rst_in  (cfg_rst_in),
      .spi_sdo     (lmk_spi_sdo[g]),
      .frame       (frame_bus[g]),
      .spi_clk     (lmk_spi_clk[g]),
      .spi_cs      (lmk_spi_cs[g]),
      .spi_sdi     (lmk_spi_sdi[g]),
      .cap_valid   (cap_valid[g]),
      .cap_data    (cap_data[g])
    );
  end

  lmk_rd_merge u_rd_merge (
    .cfg_spi_clk (cfg_spi_clk),
    .cfg_rst_in  (cfg_rst_in),
    .cap_valid   (cap_valid),
    .cap_data    (cap_data),
    .rd_valid    (lmk_rd_valid),
    .rd_data     (lmk_rd_parameter),
    .rd_chip     (lmk_rd_chip)
  );

endmodule

/* tb_lmk_cfg.sv */
// testbench for lmk_cfg_top that replays lmk_stim.txt against SPI chip models and checks results
`include "lmk_config.svh"

module tb_lmk_cfg;
  import lmk_pkg::*;

  localparam int NCH      = `LMK_NUM_CHIPS;
  localparam int STIM_LEN = 256;
  localparam int MAX_RX   = 64;
  localparam int MAX_RD   = 8;

  logic                   cfg_spi_clk;
  logic                   cfg_rst_in;
  logic                   lmk_cfg_valid;
  lmk_op_e                lmk_cfg_op;
  lmk_chip_mask_t         lmk_cfg_mask;
  lmk_addr_t              lmk_cfg_addr;
  lmk_word_t              lmk_cfg_data;
  logic [NCH-1:0]         lmk_spi_sdo;
  logic [NCH-1:0]         lmk_spi_clk;
  logic [NCH-1:0]         lmk_spi_cs;
  logic [NCH-1:0]         lmk_spi_sdi;
  logic                   lmk_busy;
  logic                   lmk_done;
  logic                   lmk_rd_valid;
  lmk_word_t              lmk_rd_parameter;
  logic [`LMK_CHIP_W-1:0] lmk_rd_chip;

  lmk_word_t   stim [STIM_LEN];
  int          ptr;
  int          num_tests;
  int          err_cnt;
  int          pass_cnt;
  int          fail_cnt;
  int          cycle_cnt   = 0;
  int          cycle_limit = 1000000;
  int unsigned seed_val;

  // chip model state with counters that only grow
  lmk_word_t      rb_val [NCH];
  lmk_word_t      rx_sh [NCH];
  int             rx_bits [NCH];
  int             rx_cnt [NCH];
  lmk_word_t      rx_frames [NCH][MAX_RX];
  int             rx_lens [NCH][MAX_RX];
  logic [NCH-1:0] clk_prev;
  logic [NCH-1:0] cs_prev;

  lmk_cfg_top u_lmk_cfg_top (
    .cfg_spi_clk      (cfg_spi_clk),
    .cfg_rst_in       (cfg_rst_in),
    .lmk_cfg_valid    (lmk_cfg_valid),
    .lmk_cfg_op       (lmk_cfg_op),
    .lmk_cfg_mask     (lmk_cfg_mask),
    .lmk_cfg_addr     (lmk_cfg_addr),
    .lmk_cfg_data     (lmk_cfg_data),
    .lmk_spi_sdo      (lmk_spi_sdo),
    .lmk_spi_clk      (lmk_spi_clk),
    .lmk_spi_cs       (lmk_spi_cs),
    .lmk_spi_sdi      (lmk_spi_sdi),
    .lmk_busy         (lmk_busy),
    .lmk_done         (lmk_done),
    .lmk_rd_valid     (lmk_rd_valid),
    .lmk_rd_parameter (lmk_rd_parameter),
    .lmk_rd_chip      (lmk_rd_chip)
  );

  initial begin
    cfg_spi_clk = 1'b0;
    forever #10 cfg_spi_clk = ~cfg_spi_clk;
  end

  always @(posedge cfg_spi_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("run stopped at %0d cycles before all tests finished", cycle_cnt);
      $display("Test FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // one chip model per link sampled mid-cycle
  ////////////////////////////////////////////////////////////
  always @(negedge cfg_spi_clk) begin
    for (int c = 0; c < NCH; c++) begin
      if (lmk_spi_cs[c] === 1'b0) begin
        if (lmk_spi_clk[c] && !clk_prev[c]) begin
          rx_sh[c]   = {rx_sh[c][`LMK_WORD_W-2:0], lmk_spi_sdi[c]};
          rx_bits[c] = rx_bits[c] + 1;
        end
        // readback bits move only while the link clock is low
        if (!lmk_spi_clk[c] && rx_bits[c] < `LMK_WORD_W) begin
          lmk_spi_sdo[c] = rb_val[c][`LMK_WORD_W-1-rx_bits[c]];
        end
      end else begin
        if (cs_prev[c] === 1'b0) begin
          if (rx_cnt[c] < MAX_RX) begin
            rx_frames[c][rx_cnt[c]] = rx_sh[c];
            rx_lens[c][rx_cnt[c]]   = rx_bits[c];
          end
          rx_cnt[c] = rx_cnt[c] + 1;
        end
        rx_bits[c]     = 0;
        lmk_spi_sdo[c] = 1'b0;
      end
      clk_prev[c] = lmk_spi_clk[c];
      cs_prev[c]  = lmk_spi_cs[c];
    end
  end

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////
  task automatic check_word(input string what, input lmk_word_t got, input lmk_word_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %08h, expected %08h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_chip(input string what, input logic [`LMK_CHIP_W-1:0] got,
                            input logic [`LMK_CHIP_W-1:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is chip %0d, expected chip %0d", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  function automatic int frames_for_op(input lmk_op_e op);
    case (op)
      OP_INIT:  return `LMK_INIT_WORDS;
      OP_WRITE: return `LMK_WRITE_WORDS;
      OP_READ:  return `LMK_READ_WORDS;
      default:  return 0;
    endcase
  endfunction

  // 68 cycles per frame plus slack per test
  function automatic int timeout_cycles();
    int p;
    int next_p;
    int total;
    p     = 1;
    total = 40;
    for (int t = 0; t < num_tests; t++) begin
      total  = total + frames_for_op(lmk_op_e'(stim[p+1][1:0])) * 68 + 200;
      next_p = p + 5 + 2 * NCH;
      for (int c = 0; c < NCH; c++) begin
        next_p = next_p + int'(stim[p+5+NCH+c]);
      end
      p = next_p;
    end
    return total;
  endfunction

  task automatic close_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("%s: pass", name);
    end else begin
      fail_cnt++;
      $display("%s: fail", name);
    end
  endtask

  task automatic run_test(input int t);
    int             kind;
    lmk_op_e        op;
    lmk_chip_mask_t mask;
    lmk_addr_t      cmd_addr;
    lmk_word_t      cmd_data;
    int             n_exp [NCH];
    int             exp_at [NCH];
    int             base [NCH];
    int             errs_before;
    int             done_cnt;
    int             rd_cnt;
    int             tail;
    int             k;
    lmk_word_t      rd_seen [MAX_RD];
    logic [`LMK_CHIP_W-1:0] chip_seen [MAX_RD];
    errs_before = err_cnt;
    kind        = int'(stim[ptr]);
    op          = lmk_op_e'(stim[ptr+1][1:0]);
    mask        = lmk_chip_mask_t'(stim[ptr+2]);
    cmd_addr    = lmk_addr_t'(stim[ptr+3]);
    cmd_data    = stim[ptr+4];
    for (int c = 0; c < NCH; c++) begin
      rb_val[c] = stim[ptr+5+c];
      n_exp[c]  = int'(stim[ptr+5+NCH+c]);
    end
    for (int c = 0; c < NCH; c++) begin
      exp_at[c] = ptr + 5 + 2 * NCH;
      for (int j = 0; j < c; j++) begin
        exp_at[c] = exp_at[c] + n_exp[j];
      end
    end
    ptr = exp_at[NCH-1] + n_exp[NCH-1];

    repeat (2 + ($urandom % 10)) @(negedge cfg_spi_clk);
    for (int c = 0; c < NCH; c++) begin
      base[c] = rx_cnt[c];
    end
    lmk_cfg_valid = 1'b1;
    lmk_cfg_op    = op;
    lmk_cfg_mask  = mask;
    lmk_cfg_addr  = cmd_addr;
    lmk_cfg_data  = cmd_data;
    @(negedge cfg_spi_clk);
    lmk_cfg_valid = 1'b0;

    // a second command while busy must be dropped
    if (kind == 1) begin
      repeat (4) @(negedge cfg_spi_clk);
      check_word("busy before extra strobe", lmk_word_t'(lmk_busy), 32'd1);
      lmk_cfg_valid = 1'b1;
      lmk_cfg_op    = OP_READ;
      lmk_cfg_mask  = '1;
      @(negedge cfg_spi_clk);
      lmk_cfg_valid = 1'b0;
    end

    done_cnt = 0;
    rd_cnt   = 0;
    tail     = 0;
    while (tail < NCH + 3) begin
      @(negedge cfg_spi_clk);
      if (lmk_done === 1'b1) begin
        done_cnt++;
      end
      if (lmk_rd_valid === 1'b1) begin
        if (rd_cnt < MAX_RD) begin
          rd_seen[rd_cnt]   = lmk_rd_parameter;
          chip_seen[rd_cnt] = lmk_rd_chip;
        end
        rd_cnt++;
      end
      if (done_cnt > 0) begin
        tail++;
      end
    end

    check_count("done pulses", done_cnt, 1);
    check_word("busy after done", lmk_word_t'(lmk_busy), '0);
    for (int c = 0; c < NCH; c++) begin
      check_count($sformatf("chip %0d frame count", c), rx_cnt[c] - base[c], n_exp[c]);
      for (k = 0; k < n_exp[c] && k < rx_cnt[c] - base[c]; k++) begin
        check_word($sformatf("chip %0d frame %0d", c, k), rx_frames[c][base[c]+k],
                   stim[exp_at[c]+k]);
        check_count($sformatf("chip %0d frame %0d bits", c, k), rx_lens[c][base[c]+k],
                    `LMK_WORD_W);
      end
    end

    // one readback per selected chip with the lowest chip first
    k = 0;
    for (int c = 0; c < NCH; c++) begin
      if (op == OP_READ && mask[c]) begin
        if (k < rd_cnt && k < MAX_RD) begin
          check_chip($sformatf("readback %0d", k), chip_seen[k], `LMK_CHIP_W'(c));
          check_word($sformatf("readback %0d data", k), rd_seen[k], rb_val[c]);
        end
        k++;
      end
    end
    check_count("readback pulses", rd_cnt, k);
    close_test($sformatf("test %0d %s mask %b", t, op.name(), mask), errs_before);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int errs_before;
    seed_val      = $urandom(32'he9e2);
    cfg_rst_in    = 1'b1;
    lmk_cfg_valid = 1'b0;
    lmk_cfg_op    = OP_NONE;
    lmk_cfg_mask  = '0;
    lmk_cfg_addr  = '0;
    lmk_cfg_data  = '0;
    lmk_spi_sdo   = '0;
    err_cnt       = 0;
    pass_cnt      = 0;
    fail_cnt      = 0;
    for (int c = 0; c < NCH; c++) begin
      rb_val[c]  = '0;
      rx_sh[c]   = '0;
      rx_bits[c] = 0;
      rx_cnt[c]  = 0;
    end
    clk_prev = '0;
    cs_prev  = '1;

    $readmemh("lmk_stim.txt", stim);
    if ($isunknown(stim[0])) begin
      $display("stimulus file lmk_stim.txt could not be read");
      $display("Test FAILED");
      $finish;
    end else begin
      num_tests   = int'(stim[0]);
      ptr         = 1;
      cycle_limit = timeout_cycles();

      repeat (8) @(posedge cfg_spi_clk);
      @(negedge cfg_spi_clk);
      cfg_rst_in  = 1'b0;
      errs_before = err_cnt;
      check_word("cs after reset", lmk_word_t'(lmk_spi_cs), lmk_word_t'({NCH{1'b1}}));
      check_word("spi clock after reset", lmk_word_t'(lmk_spi_clk), '0);
      check_word("status after reset", lmk_word_t'({lmk_busy, lmk_done, lmk_rd_valid}), '0);
      close_test("reset state", errs_before);

      for (int t = 1; t <= num_tests; t++) begin
        run_test(t);
      end

      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0) begin
        $display("Test OK");
      end else begin
        $display("Test FAILED");
      end
      $finish;
    end
  end

endmodule

/* lmk_stim.txt */
// per test: kind op mask addr data rb0 rb1 n0 n1, then n0 chip 0 frames and n1 chip 1 frames
// kind 1 strobes a read of both chips while busy; op 1 init, 2 write, 3 read; test count first
5
// init both chips
0 1 3 00 00000000 00000000 00000000 e e
80160180 80140300 00140181 00140182 00140063 40140024 80140605
01000006 01110007 00010008 55555549 90c2410a 040c300b 0000003f
80160180 80140320 80140321 80140142 40140023 80140324 80140325
00000006 01000007 00000008 55555549 9002410a 340c300b 0000003f
// write chip 1 only
0 2 2 00 12345678 00000000 00000000 0 3
0000001f 12345678 0000003f
// read address 5 from chip 0
0 3 1 05 00000000 a5c30f96 00000000 2 0
0005001f 00000000
// read address 11 from both chips
0 3 3 0b 00000000 1234abcd fedc0042 2 2
000b001f 00000000
000b001f 00000000
// write chip 0 with a second strobe while busy
1 2 1 00 cafe0001 00000000 00000000 3 0
0000001f cafe0001 0000003f

/* all.f */
+incdir+.
lmk_pkg.sv
lmk_regmap_pkg.sv
lmk_frame_if.sv
lmk_cmd_seq.sv
lmk_spi_channel.sv
lmk_rd_merge.sv
lmk_cfg_top.sv
tb_lmk_cfg.sv

/* Bender.yml */
package:
  name: lmk_cfg

export_include_dirs:
  - .

sources:
  - lmk_pkg.sv
  - lmk_regmap_pkg.sv
  - lmk_frame_if.sv
  - lmk_cmd_seq.sv
  - lmk_spi_channel.sv
  - lmk_rd_merge.sv
  - lmk_cfg_top.sv
  - target: simulation
    files:
      - tb_lmk_cfg.sv
